//--- source/msx_bus_pkg.sv
package msx_bus_pkg;

  // CPU bus seen by the glue, control lines active low
  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  data;     // CPU data out
    logic        n_rd;
    logic        n_wr;
    logic        n_mreq;
    logic        n_iorq;
  } cpu_bus_t;

  // One flag per decoded access
  typedef struct packed {
    logic vdp_data_wr;
    logic vdp_data_rd;
    logic vdp_ctrl_wr;
    logic vdp_ctrl_rd;     // Status read
    logic ppi_a_wr;
    logic ppi_a_rd;
    logic ppi_b_rd;
    logic ppi_c_wr;
    logic ppi_c_rd;
    logic ppi_cmd_wr;
    logic psg_reg_wr;
    logic psg_val_rd;
    logic mem_wr;
    logic mem_rd;
  } io_strobe_t;

  localparam logic [7:0] vdp_data_port = 8'h98;
  localparam logic [7:0] vdp_ctrl_port = 8'h99;
  localparam logic [7:0] psg_reg_port  = 8'ha0;
  localparam logic [7:0] psg_read_port = 8'ha2;
  localparam logic [7:0] ppi_a_port    = 8'ha8;
  localparam logic [7:0] ppi_b_port    = 8'ha9;
  localparam logic [7:0] ppi_c_port    = 8'haa;
  localparam logic [7:0] ppi_cmd_port  = 8'hab;

  localparam logic [3:0] joystick_reg  = 4'd14;  // PSG register for joystick

endpackage

//--- source/msx_vdp_pkg.sv
package msx_vdp_pkg;

  // Second control byte, register write view
  typedef struct packed {
    logic       is_reg;    // Set for a register write
    logic       spare;
    logic [5:0] reg_num;
  } vdp_reg_wr_t;

  // Second control byte, address load view
  typedef struct packed {
    logic       is_reg;    // Clear for an address load
    logic       dir;       // Read or write setup
    logic [5:0] addr_hi;
  } vdp_addr_ld_t;

  typedef union packed {
    vdp_reg_wr_t  reg_wr;
    vdp_addr_ld_t addr_ld;
  } vdp_ctrl_byte_u;

  typedef enum logic [1:0] {
    mode_text       = 2'd0,
    mode_graphic1   = 2'd1,
    mode_graphic2   = 2'd2,
    mode_multicolor = 2'd3
  } vdp_mode_e;

  // Settings handed to the video engine
  typedef struct packed {
    vdp_mode_e   mode;
    logic [13:0] name_table_addr;
    logic [13:0] color_table_addr;
    logic [13:0] font_addr;
    logic [13:0] sprite_attr_addr;
    logic [13:0] sprite_pattern_addr;
    logic        video_on;
    logic        int_enable;
    logic        sprite_large;
    logic        sprite_mag;
    logic [3:0]  text_color;
    logic [3:0]  back_color;
  } vdp_config_t;

  // Pulses from the video engine
  typedef struct packed {
    logic       interrupt;
    logic       collision;
    logic       too_many;
    logic [4:0] sprite5;   // Fifth sprite number
  } vdp_events_t;

endpackage

//--- source/cpu_clock_enable.sv
`timescale 1ns/1ns

module cpu_clock_enable #(
  parameter int clk_div = 7
) (
  input  logic i_cpu_clock,
  input  logic i_n_hard_reset,
  output logic o_clock_enable,
  output logic o_clock_edge
);

  // Needs at least 3 bits, the enable is taken from bit 2
  localparam int cnt_w = (clk_div > 8) ? $clog2(clk_div) : 3;

  logic [cnt_w-1:0] count;
  logic             enable_d;

  always_ff @(posedge i_cpu_clock) begin
    if (!i_n_hard_reset) begin
      count    <= '0;
      enable_d <= 1'b0;
    end else begin
      enable_d <= count[2];
      if (count == cnt_w'(clk_div - 1)) count <= '0;  // Wrap
      else count <= count + 1'b1;
    end
  end

  assign o_clock_enable = count[2];
  assign o_clock_edge   = count[2] & ~enable_d;  // Rising edge only

endmodule

//--- source/io_port_decode.sv
`timescale 1ns/1ns

module io_port_decode
  import msx_bus_pkg::*;
(
  input  cpu_bus_t   i_cpu_bus,
  output io_strobe_t o_strobe
);

  logic       io_wr;
  logic       io_rd;
  logic [7:0] port;

  // Request and direction lines combined, active high
  assign io_wr = ~(i_cpu_bus.n_wr | i_cpu_bus.n_iorq);
  assign io_rd = ~(i_cpu_bus.n_rd | i_cpu_bus.n_iorq);
  assign port  = i_cpu_bus.addr[7:0];

  always_comb begin
    o_strobe.vdp_data_wr = io_wr && (port == vdp_data_port);
    o_strobe.vdp_data_rd = io_rd && (port == vdp_data_port);
    o_strobe.vdp_ctrl_wr = io_wr && (port == vdp_ctrl_port);
    o_strobe.vdp_ctrl_rd = io_rd && (port == vdp_ctrl_port);
    o_strobe.ppi_a_wr    = io_wr && (port == ppi_a_port);
    o_strobe.ppi_a_rd    = io_rd && (port == ppi_a_port);
    o_strobe.ppi_b_rd    = io_rd && (port == ppi_b_port);
    o_strobe.ppi_c_wr    = io_wr && (port == ppi_c_port);
    o_strobe.ppi_c_rd    = io_rd && (port == ppi_c_port);
    o_strobe.ppi_cmd_wr  = io_wr && (port == ppi_cmd_port);
    o_strobe.psg_reg_wr  = io_wr && (port == psg_reg_port);
    o_strobe.psg_val_rd  = io_rd && (port == psg_read_port);
    // Memory side
    o_strobe.mem_wr      = ~(i_cpu_bus.n_wr | i_cpu_bus.n_mreq);
    o_strobe.mem_rd      = ~(i_cpu_bus.n_rd | i_cpu_bus.n_mreq);
  end

endmodule

//--- source/vdp_cpu_port.sv
`timescale 1ns/1ns

module vdp_cpu_port
  import msx_bus_pkg::*;
  import msx_vdp_pkg::*;
(
  input  logic        i_cpu_clock,
  input  logic        i_n_hard_reset,
  input  logic        i_clock_edge,
  input  io_strobe_t  i_strobe,
  input  logic [7:0]  i_cpu_data,
  input  vdp_events_t i_vdp_events,
  output logic        o_vram_wr,
  output logic        o_vram_rd,
  output logic [13:0] o_vram_addr,
  output vdp_config_t o_config,
  output logic [7:0]  o_status
);

  logic [7:0]     vdp_reg [8];
  logic [7:0]     first_byte;
  logic           second_byte;   // Byte toggle
  logic           vram_rd_d;
  logic           status_rd_d;
  logic           int_flag;
  logic           coll_flag;
  vdp_ctrl_byte_u ctrl_byte;
  vdp_mode_e      mode;

  assign ctrl_byte = i_cpu_data;

  // ========================================
  // Control sequence and VRAM address
  // ========================================
  always_ff @(posedge i_cpu_clock) begin
    if (!i_n_hard_reset) begin
      second_byte <= 1'b0;
      vram_rd_d   <= 1'b0;
      o_vram_addr <= '0;
      for (int i = 0; i < 8; i++) vdp_reg[i] <= '0;
    end else if (i_clock_edge) begin
      vram_rd_d <= i_strobe.vdp_data_rd;
      if (i_strobe.vdp_data_wr) o_vram_addr <= o_vram_addr + 1'b1;
      else if (vram_rd_d && !i_strobe.vdp_data_rd) o_vram_addr <= o_vram_addr + 1'b1;
      if (i_strobe.vdp_ctrl_wr) begin
        second_byte <= ~second_byte;
        if (second_byte) begin
          if (!ctrl_byte.addr_ld.is_reg)
            o_vram_addr <= {ctrl_byte.addr_ld.addr_hi, first_byte};
          else if (ctrl_byte.reg_wr.reg_num < 6'd8)
            vdp_reg[ctrl_byte.reg_wr.reg_num[2:0]] <= first_byte;
        end
      end
    end
  end

  always_ff @(posedge i_cpu_clock) begin
    if (i_clock_edge && i_strobe.vdp_ctrl_wr && !second_byte) first_byte <= i_cpu_data;
  end

  assign o_vram_wr = i_strobe.vdp_data_wr & i_clock_edge;
  assign o_vram_rd = i_strobe.vdp_data_rd & i_clock_edge;

  // ========================================
  // Status flags, cleared after a read
  // ========================================
  always_ff @(posedge i_cpu_clock) begin
    if (!i_n_hard_reset) begin
      int_flag    <= 1'b0;
      coll_flag   <= 1'b0;
      status_rd_d <= 1'b0;
    end else begin
      if (i_vdp_events.interrupt) int_flag <= 1'b1;
      if (i_vdp_events.collision) coll_flag <= 1'b1;
      if (i_clock_edge) begin
        status_rd_d <= i_strobe.vdp_ctrl_rd;
        if (status_rd_d && !i_strobe.vdp_ctrl_rd) begin  // Read just ended
          int_flag  <= 1'b0;
          coll_flag <= 1'b0;
        end
      end
    end
  end

  assign o_status = {int_flag, i_vdp_events.too_many, coll_flag,
                     i_vdp_events.too_many ? i_vdp_events.sprite5 : 5'b11111};

  // ========================================
  // Mode and table addresses
  // ========================================
  always_comb begin
    if (vdp_reg[1][3]) mode = mode_multicolor;
    else if (vdp_reg[0][1]) mode = mode_graphic2;
    else if (vdp_reg[1][4]) mode = mode_text;
    else mode = mode_graphic1;
  end

  always_comb begin
    o_config.mode             = mode;
    o_config.name_table_addr  = {vdp_reg[2][3:0], 10'b0};    // x1024
    o_config.color_table_addr = (mode == mode_graphic2) ? {vdp_reg[3][7], 13'b0}
                                                        : {vdp_reg[3], 6'b0};
    o_config.font_addr        = (mode == mode_graphic2) ? {vdp_reg[4][2], 13'b0}
                                                        : {vdp_reg[4][2:0], 11'b0};
    o_config.sprite_attr_addr    = {vdp_reg[5][6:0], 7'b0};  // x128
    o_config.sprite_pattern_addr = {vdp_reg[6][2:0], 11'b0};
    o_config.video_on         = vdp_reg[1][6];
    o_config.int_enable       = vdp_reg[1][5];
    o_config.sprite_large     = vdp_reg[1][1];
    o_config.sprite_mag       = vdp_reg[1][0];
    o_config.text_color       = vdp_reg[7][7:4];
    o_config.back_color       = vdp_reg[7][3:0];
  end

endmodule

//--- source/ppi_psg_regs.sv
`timescale 1ns/1ns

module ppi_psg_regs
  import msx_bus_pkg::*;
(
  input  logic       i_cpu_clock,
  input  logic       i_n_hard_reset,
  input  logic       i_clock_edge,
  input  io_strobe_t i_strobe,
  input  logic [7:0] i_cpu_data,
  output logic [7:0] o_ppi_port_a,   // Slot select
  output logic [7:0] o_ppi_port_c,
  output logic [3:0] o_psg_reg
);

  always_ff @(posedge i_cpu_clock) begin
    if (!i_n_hard_reset) begin
      o_ppi_port_a <= '0;
      o_ppi_port_c <= '0;
      o_psg_reg    <= '0;
    end else if (i_clock_edge) begin
      if (i_strobe.ppi_a_wr) o_ppi_port_a <= i_cpu_data;
      if (i_strobe.ppi_c_wr) o_ppi_port_c <= i_cpu_data;
      // Bit set/reset command
      if (i_strobe.ppi_cmd_wr && !i_cpu_data[7])
        o_ppi_port_c[i_cpu_data[3:1]] <= i_cpu_data[0];
      if (i_strobe.psg_reg_wr) o_psg_reg <= i_cpu_data[3:0];
    end
  end

endmodule

//--- source/slot_decoder.sv
`timescale 1ns/1ns

module slot_decoder
  import msx_bus_pkg::*;
(
  input  io_strobe_t  i_strobe,
  input  logic [15:0] i_address,
  input  logic [7:0]  i_ppi_port_a,
  input  logic [7:0]  i_ppi_port_b,
  input  logic [7:0]  i_ppi_port_c,
  input  logic [3:0]  i_psg_reg,
  input  logic [5:0]  i_btn,
  input  logic        i_rom_32k,
  input  logic [7:0]  i_vram_rdata,
  input  logic [7:0]  i_status,
  input  logic [7:0]  i_ram_data,
  input  logic [7:0]  i_rom_data,
  output logic        o_ram_we,
  output logic [7:0]  o_cpu_data_in
);

  logic [1:0] page;
  logic [1:0] page_slot;
  logic       rom_sel;
  logic [7:0] joystick;

  // Each 16 KB page has a two bit slot field in port A
  assign page      = i_address[15:14];
  assign page_slot = i_ppi_port_a[{page, 1'b0} +: 2];

  assign o_ram_we = i_address[15] && (page_slot == 2'd0) && i_strobe.mem_wr;

  // Cartridge in slot 1, page 1 only with a 32K ROM
  assign rom_sel  = (page_slot == 2'd1) && ((page == 2'd1 && i_rom_32k) || page == 2'd2);
  assign joystick = {2'b00, ~i_btn};

  always_comb begin
    if (i_strobe.ppi_a_rd) o_cpu_data_in = i_ppi_port_a;
    else if (i_strobe.ppi_b_rd) o_cpu_data_in = i_ppi_port_b;
    else if (i_strobe.ppi_c_rd) o_cpu_data_in = i_ppi_port_c;
    else if (i_strobe.vdp_data_rd) o_cpu_data_in = i_vram_rdata;
    else if (i_strobe.vdp_ctrl_rd) o_cpu_data_in = i_status;
    else if (i_strobe.psg_val_rd && i_psg_reg == joystick_reg) o_cpu_data_in = joystick;
    else if (i_strobe.mem_rd && rom_sel) o_cpu_data_in = i_rom_data;
    else if (i_strobe.mem_rd && page_slot == 2'd0) o_cpu_data_in = i_ram_data;
    else o_cpu_data_in = 8'h00;
  end

endmodule

//--- source/msx_io_top.sv
`timescale 1ns/1ns

module msx_io_top
  import msx_bus_pkg::*;
  import msx_vdp_pkg::*;
#(
  parameter int clk_div = 7
) (
  input  logic        i_cpu_clock,
  input  logic        i_n_hard_reset,
  input  cpu_bus_t    i_cpu_bus,
  input  logic [7:0]  i_ram_data,
  input  logic [7:0]  i_rom_data,
  input  logic [7:0]  i_ppi_port_b,   // Keyboard column data
  input  logic [5:0]  i_btn,
  input  logic        i_rom_32k,
  input  vdp_events_t i_vdp_events,
  input  logic [7:0]  i_vram_rdata,
  output logic [7:0]  o_cpu_data_in,
  output logic        o_clock_enable,
  output logic        o_ram_we,
  output logic        o_vram_wr,
  output logic        o_vram_rd,
  output logic [13:0] o_vram_addr,
  output vdp_config_t o_vdp_config,
  output logic [7:0]  o_ppi_port_a,
  output logic [7:0]  o_ppi_port_c
);

  logic       cpuClock;
  logic       n_hard_reset;
  logic       clock_edge;
  io_strobe_t strobe;
  logic [7:0] vdp_status;
  logic [3:0] psg_reg;

  assign cpuClock     = i_cpu_clock;
  assign n_hard_reset = i_n_hard_reset;

  cpu_clock_enable #(
    .clk_div(clk_div)
  ) u_clock_enable (
    .i_cpu_clock   (cpuClock),
    .i_n_hard_reset(n_hard_reset),
    .o_clock_enable(o_clock_enable),
    .o_clock_edge  (clock_edge)
  );

  io_port_decode u_decode (
    .i_cpu_bus(i_cpu_bus),
    .o_strobe (strobe)
  );

  vdp_cpu_port u_vdp_port (
    .i_cpu_clock   (cpuClock),
    .i_n_hard_reset(n_hard_reset),
    .i_clock_edge  (clock_edge),
    .i_strobe      (strobe),
    .i_cpu_data    (i_cpu_bus.data),
    .i_vdp_events  (i_vdp_events),
    .o_vram_wr     (o_vram_wr),
    .o_vram_rd     (o_vram_rd),
    .o_vram_addr   (o_vram_addr),
    .o_config      (o_vdp_config),
    .o_status      (vdp_status)
  );

  ppi_psg_regs u_ppi_psg (
    .i_cpu_clock   (cpuClock),
    .i_n_hard_reset(n_hard_reset),
    .i_clock_edge  (clock_edge),
    .i_strobe      (strobe),
    .i_cpu_data    (i_cpu_bus.data),
    .o_ppi_port_a  (o_ppi_port_a),
    .o_ppi_port_c  (o_ppi_port_c),
    .o_psg_reg     (psg_reg)
  );

  slot_decoder u_slots (
    .i_strobe     (strobe),
    .i_address    (i_cpu_bus.addr),
    .i_ppi_port_a (o_ppi_port_a),
    .i_ppi_port_b (i_ppi_port_b),
    .i_ppi_port_c (o_ppi_port_c),
    .i_psg_reg    (psg_reg),
    .i_btn        (i_btn),
    .i_rom_32k    (i_rom_32k),
    .i_vram_rdata (i_vram_rdata),
    .i_status     (vdp_status),
    .i_ram_data   (i_ram_data),
    .i_rom_data   (i_rom_data),
    .o_ram_we     (o_ram_we),
    .o_cpu_data_in(o_cpu_data_in)
  );

endmodule

//--- tb/msx_io_sva.sv
`timescale 1ns/1ns

module msx_io_sva
  import msx_bus_pkg::*;
  import msx_vdp_pkg::*;
(
  input logic        i_clk,
  input logic        i_n_rst,
  input logic        i_edge,
  input cpu_bus_t    i_bus,
  input logic [7:0]  i_ram_data,
  input logic [7:0]  i_rom_data,
  input logic [7:0]  i_ppi_port_b,
  input logic [5:0]  i_btn,
  input logic        i_rom_32k,
  input vdp_events_t i_events,
  input logic [7:0]  i_vram_rdata,
  input logic [7:0]  i_cpu_data_in,
  input logic        i_clock_enable,
  input logic        i_ram_we,
  input logic        i_vram_wr,
  input logic        i_vram_rd,
  input logic [13:0] i_vram_addr,
  input vdp_config_t i_config,
  input logic [7:0]  i_ppi_port_a,
  input logic [7:0]  i_ppi_port_c
);

  int fail_count = 0;

  logic        io_wr;
  logic        io_rd;
  logic        mem_wr;
  logic        mem_rd;
  logic [7:0]  port;
  logic [1:0]  page;
  logic [1:0]  slot;
  logic        ctrl_wr;
  logic        ctrl_rd;
  logic        data_wr;
  logic        data_rd;
  logic [7:0]  m_reg [8];    // Reference VDP registers
  logic [7:0]  m_first;
  logic        m_toggle;
  logic [13:0] m_vaddr;
  logic        m_rd_prev;    // VRAM read seen at the last edge
  logic        m_srd_prev;   // Status read seen at the last edge
  logic        m_int;
  logic        m_coll;
  logic [7:0]  m_a;
  logic [7:0]  m_c;
  logic [3:0]  m_psg;
  logic [7:0]  exp_status;
  logic [7:0]  exp_data;
  vdp_config_t exp_config;

  task automatic value_mismatch(input string name, input logic [95:0] expected,
                                input logic [95:0] actual);
    fail_count++;
    $error("Fail %s: expected %h, actual %h", name, expected, actual);
  endtask

  task automatic report_rule(input string what);
    fail_count++;
    $error("%s", what);
  endtask

  assign io_wr   = !i_bus.n_wr && !i_bus.n_iorq;
  assign io_rd   = !i_bus.n_rd && !i_bus.n_iorq;
  assign mem_wr  = !i_bus.n_wr && !i_bus.n_mreq;
  assign mem_rd  = !i_bus.n_rd && !i_bus.n_mreq;
  assign port    = i_bus.addr[7:0];
  assign page    = i_bus.addr[15:14];
  assign slot    = 2'(m_a >> (2 * page));   // Two bits per page
  assign ctrl_wr = io_wr && port == vdp_ctrl_port;
  assign ctrl_rd = io_rd && port == vdp_ctrl_port;
  assign data_wr = io_wr && port == vdp_data_port;
  assign data_rd = io_rd && port == vdp_data_port;

  // ========================================
  // Reference state from the bus rules
  // ========================================
  always_ff @(posedge i_clk) begin
    if (!i_n_rst) begin
      m_first    <= '0;
      m_toggle   <= 1'b0;
      m_vaddr    <= '0;
      m_rd_prev  <= 1'b0;
      m_srd_prev <= 1'b0;
      m_int      <= 1'b0;
      m_coll     <= 1'b0;
      m_a        <= '0;
      m_c        <= '0;
      m_psg      <= '0;
      for (int i = 0; i < 8; i++) m_reg[i] <= '0;
    end else begin
      if (i_events.interrupt) m_int <= 1'b1;
      if (i_events.collision) m_coll <= 1'b1;
      if (i_edge) begin
        m_rd_prev  <= data_rd;
        m_srd_prev <= ctrl_rd;
        if (m_srd_prev && !ctrl_rd) begin   // Clear on read
          m_int  <= 1'b0;
          m_coll <= 1'b0;
        end
        if (data_wr || (m_rd_prev && !data_rd)) m_vaddr <= m_vaddr + 14'd1;
        if (ctrl_wr) begin
          m_toggle <= !m_toggle;
          if (!m_toggle) m_first <= i_bus.data;
          else if (!i_bus.data[7]) m_vaddr <= {i_bus.data[5:0], m_first};
          else if (i_bus.data[5:3] == 3'd0) m_reg[i_bus.data[2:0]] <= m_first;
        end
        if (io_wr && port == ppi_a_port) m_a <= i_bus.data;
        if (io_wr && port == ppi_c_port) m_c <= i_bus.data;
        if (io_wr && port == ppi_cmd_port && !i_bus.data[7])
          m_c[i_bus.data[3:1]] <= i_bus.data[0];
        if (io_wr && port == psg_reg_port) m_psg <= i_bus.data[3:0];
      end
    end
  end

  always_comb begin
    if (m_reg[1][3]) exp_config.mode = mode_multicolor;
    else if (m_reg[0][1]) exp_config.mode = mode_graphic2;
    else if (m_reg[1][4]) exp_config.mode = mode_text;
    else exp_config.mode = mode_graphic1;
    exp_config.name_table_addr = 14'(m_reg[2] * 1024);
    if (exp_config.mode == mode_graphic2) begin
      exp_config.color_table_addr = 14'(m_reg[3][7] * 8192);
      exp_config.font_addr        = 14'(m_reg[4][2] * 8192);
    end else begin
      exp_config.color_table_addr = 14'(m_reg[3] * 64);
      exp_config.font_addr        = 14'(m_reg[4] * 2048);
    end
    exp_config.sprite_attr_addr    = 14'(m_reg[5] * 128);
    exp_config.sprite_pattern_addr = 14'(m_reg[6] * 2048);
    exp_config.video_on     = m_reg[1][6];
    exp_config.int_enable   = m_reg[1][5];
    exp_config.sprite_large = m_reg[1][1];
    exp_config.sprite_mag   = m_reg[1][0];
    exp_config.text_color   = m_reg[7][7:4];
    exp_config.back_color   = m_reg[7][3:0];
  end

  assign exp_status = {m_int, i_events.too_many, m_coll,
                       i_events.too_many ? i_events.sprite5 : 5'h1f};

  always_comb begin
    if (io_rd && port == ppi_a_port) exp_data = m_a;
    else if (io_rd && port == ppi_b_port) exp_data = i_ppi_port_b;
    else if (io_rd && port == ppi_c_port) exp_data = m_c;
    else if (data_rd) exp_data = i_vram_rdata;
    else if (ctrl_rd) exp_data = exp_status;
    else if (io_rd && port == psg_read_port && m_psg == joystick_reg)
      exp_data = {2'b00, ~i_btn};
    else if (mem_rd && slot == 2'd1 && ((page == 2'd1 && i_rom_32k) || page == 2'd2))
      exp_data = i_rom_data;
    else if (mem_rd && slot == 2'd0) exp_data = i_ram_data;
    else exp_data = 8'h00;
  end

  // ========================================
  // Checks
  // ========================================
  a_enable_shape: assert property (@(posedge i_clk) disable iff (!i_n_rst)
    $rose(i_clock_enable) |-> i_clock_enable[*3] ##1 (!i_clock_enable)[*4] ##1 i_clock_enable)
    else report_rule("Clock enable is not high 3 of 7 cycles with rises 7 cycles apart");

  a_edge_pulse: assert property (@(posedge i_clk) disable iff (!i_n_rst)
    i_edge == (i_clock_enable && !$past(i_clock_enable)))
    else report_rule("Clock edge pulse does not match the rise of the enable");

  a_config: assert property (@(posedge i_clk) disable iff (!i_n_rst)
    i_config == exp_config)
    else value_mismatch("vdp_config", 96'($sampled(exp_config)), 96'($sampled(i_config)));

  a_vram_addr: assert property (@(posedge i_clk) disable iff (!i_n_rst)
    i_vram_addr == m_vaddr)
    else value_mismatch("vram_addr", 96'($sampled(m_vaddr)), 96'($sampled(i_vram_addr)));

  a_vram_strobes: assert property (@(posedge i_clk) disable iff (!i_n_rst)
    {i_vram_wr, i_vram_rd} == {i_edge && data_wr, i_edge && data_rd})
    else report_rule("VRAM strobe is not the port access gated by the clock edge");

  a_ppi_ports: assert property (@(posedge i_clk) disable iff (!i_n_rst)
    {i_ppi_port_a, i_ppi_port_c} == {m_a, m_c})
    else value_mismatch("ppi_ports", 96'($sampled({m_a, m_c})),
                        96'($sampled({i_ppi_port_a, i_ppi_port_c})));

  a_read_data: assert property (@(posedge i_clk) disable iff (!i_n_rst)
    i_cpu_data_in == exp_data)
    else value_mismatch("cpu_data_in", 96'($sampled(exp_data)), 96'($sampled(i_cpu_data_in)));

  a_ram_we: assert property (@(posedge i_clk) disable iff (!i_n_rst)
    i_ram_we == (i_bus.addr[15] && slot == 2'd0 && mem_wr))
    else value_mismatch("ram_we", 96'($sampled(i_bus.addr[15] && slot == 2'd0 && mem_wr)),
                        96'($sampled(i_ram_we)));

endmodule

bind msx_io_top msx_io_sva u_sva (
  .i_clk         (cpuClock),
  .i_n_rst       (n_hard_reset),
  .i_edge        (clock_edge),
  .i_bus         (i_cpu_bus),
  .i_ram_data    (i_ram_data),
  .i_rom_data    (i_rom_data),
  .i_ppi_port_b  (i_ppi_port_b),
  .i_btn         (i_btn),
  .i_rom_32k     (i_rom_32k),
  .i_events      (i_vdp_events),
  .i_vram_rdata  (i_vram_rdata),
  .i_cpu_data_in (o_cpu_data_in),
  .i_clock_enable(o_clock_enable),
  .i_ram_we      (o_ram_we),
  .i_vram_wr     (o_vram_wr),
  .i_vram_rd     (o_vram_rd),
  .i_vram_addr   (o_vram_addr),
  .i_config      (o_vdp_config),
  .i_ppi_port_a  (o_ppi_port_a),
  .i_ppi_port_c  (o_ppi_port_c)
);

//--- tb/msx_io_tb.sv
`timescale 1ns/1ns

module msx_io_tb
  import msx_bus_pkg::*;
  import msx_vdp_pkg::*;
();

  localparam int       edge_timeout = 40;   // Cycles, well over one enable period
  localparam cpu_bus_t idle_bus     = '{16'h0000, 8'h00, 1'b1, 1'b1, 1'b1, 1'b1};

  logic        cpuClock = 1'b0;
  logic        n_hard_reset;
  cpu_bus_t    cpu_bus;
  logic [7:0]  ram_data;
  logic [7:0]  rom_data;
  logic [7:0]  ppi_port_b;
  logic [5:0]  btn;
  logic        rom_32k;
  vdp_events_t vdp_events;
  logic [7:0]  vram_rdata;
  logic [7:0]  cpu_data_in;
  logic        clock_enable;
  logic        ram_we;
  logic        vram_wr;
  logic        vram_rd;
  logic [13:0] vram_addr;
  vdp_config_t vdp_config;
  logic [7:0]  ppi_port_a;
  logic [7:0]  ppi_port_c;
  logic        en_q = 1'b0;   // Enable of the previous cycle
  integer      seed;

  msx_io_top #(
    .clk_div(7)
  ) u_dut (
    .i_cpu_clock   (cpuClock),
    .i_n_hard_reset(n_hard_reset),
    .i_cpu_bus     (cpu_bus),
    .i_ram_data    (ram_data),
    .i_rom_data    (rom_data),
    .i_ppi_port_b  (ppi_port_b),
    .i_btn         (btn),
    .i_rom_32k     (rom_32k),
    .i_vdp_events  (vdp_events),
    .i_vram_rdata  (vram_rdata),
    .o_cpu_data_in (cpu_data_in),
    .o_clock_enable(clock_enable),
    .o_ram_we      (ram_we),
    .o_vram_wr     (vram_wr),
    .o_vram_rd     (vram_rd),
    .o_vram_addr   (vram_addr),
    .o_vdp_config  (vdp_config),
    .o_ppi_port_a  (ppi_port_a),
    .o_ppi_port_c  (ppi_port_c)
  );

  always #5 cpuClock = ~cpuClock;

  always @(posedge cpuClock) en_q <= clock_enable;

  // Stop at the first assertion failure
  always @(negedge cpuClock) begin
    if (u_dut.u_sva.fail_count != 0) begin
      $display("Test failed");
      $fatal(1, "An assertion bound into the DUT failed");
    end
  end

  // ========================================
  // Bus tasks
  // ========================================
  task automatic wait_edge_cycle();
    int n;
    n = 0;
    while (!(clock_enable && !en_q)) begin
      if (n == edge_timeout) begin
        $display("Test failed");
        $fatal(1, "No clock enable rise within %0d cycles", edge_timeout);
      end
      @(posedge cpuClock);
      #1;
      n++;
    end
  endtask

  task automatic pass_edge();
    wait_edge_cycle();
    @(posedge cpuClock);
    #1;
  endtask

  task automatic bus_cycle(input cpu_bus_t b);
    cpu_bus    = b;
    ram_data   = 8'($random(seed));   // Fresh memory and VRAM data per access
    rom_data   = 8'($random(seed));
    vram_rdata = 8'($random(seed));
    ppi_port_b = 8'($random(seed));
    pass_edge();                      // Held through one edge
    cpu_bus = idle_bus;
  endtask

  task automatic io_write(input logic [7:0] port, input logic [7:0] data);
    cpu_bus_t b;
    b        = idle_bus;
    b.addr   = {8'($random(seed)), port};
    b.data   = data;
    b.n_wr   = 1'b0;
    b.n_iorq = 1'b0;
    bus_cycle(b);
  endtask

  task automatic io_read(input logic [7:0] port);
    cpu_bus_t b;
    b        = idle_bus;
    b.addr   = {8'($random(seed)), port};
    b.n_rd   = 1'b0;
    b.n_iorq = 1'b0;
    bus_cycle(b);
  endtask

  task automatic mem_access(input logic [15:0] addr, input logic [7:0] data,
                            input logic is_write);
    cpu_bus_t b;
    b        = idle_bus;
    b.addr   = addr;
    b.data   = data;
    b.n_rd   = is_write;
    b.n_wr   = !is_write;
    b.n_mreq = 1'b0;
    bus_cycle(b);
  endtask

  task automatic vdp_reg_write(input logic [5:0] num, input logic [7:0] value);
    io_write(vdp_ctrl_port, value);
    io_write(vdp_ctrl_port, {2'b10, num});
  endtask

  task automatic pulse_event(input logic irq, input logic coll);
    vdp_events.interrupt = irq;
    vdp_events.collision = coll;
    @(posedge cpuClock);
    #1;
    vdp_events.interrupt = 1'b0;
    vdp_events.collision = 1'b0;
  endtask

  initial begin
    logic [7:0] r;
    seed         = 32'h4bf6;
    n_hard_reset = 1'b0;
    cpu_bus      = idle_bus;
    ram_data     = 8'h00;
    rom_data     = 8'h00;
    ppi_port_b   = 8'h00;
    btn          = 6'h00;
    rom_32k      = 1'b0;
    vdp_events   = '0;
    vram_rdata   = 8'h00;
    repeat (2) @(posedge cpuClock);
    #1;
    n_hard_reset = 1'b1;

    repeat (4) pass_edge();   // Several enable periods

    // Mode priority, then random register contents
    vdp_reg_write(6'd0, 8'h02);
    vdp_reg_write(6'd1, 8'h10);
    vdp_reg_write(6'd0, 8'h00);
    vdp_reg_write(6'd1, 8'h08);
    vdp_reg_write(6'd1, 8'h63);
    repeat (3) begin
      for (int i = 0; i < 8; i++) vdp_reg_write(6'(i), 8'($random(seed)));
    end
    repeat (4) begin
      r = 8'($random(seed));
      vdp_reg_write(6'(8 + (r % 56)), 8'($random(seed)));   // Out of range number
    end

    // VRAM address, including the wrap at the top
    io_write(vdp_ctrl_port, 8'($random(seed)));
    io_write(vdp_ctrl_port, {2'b01, 6'($random(seed))});
    repeat (3) io_write(vdp_data_port, 8'($random(seed)));
    io_read(vdp_data_port);
    pass_edge();
    io_write(vdp_ctrl_port, 8'hfe);
    io_write(vdp_ctrl_port, 8'h3f);
    repeat (3) io_write(vdp_data_port, 8'($random(seed)));

    // Status flags
    pulse_event(1'b1, 1'b0);
    io_read(vdp_ctrl_port);
    pass_edge();
    io_read(vdp_ctrl_port);
    vdp_events.too_many = 1'b1;
    vdp_events.sprite5  = 5'($random(seed));
    pulse_event(1'b0, 1'b1);
    io_read(vdp_ctrl_port);
    pass_edge();
    vdp_events.too_many = 1'b0;
    io_read(vdp_ctrl_port);

    // PPI and PSG
    repeat (6) begin
      io_write(ppi_a_port, 8'($random(seed)));
      io_read(ppi_a_port);
      io_write(ppi_c_port, 8'($random(seed)));
      io_read(ppi_c_port);
    end
    repeat (8) begin
      r = 8'($random(seed));
      io_write(ppi_cmd_port, {4'b0000, r[3:0]});
      io_read(ppi_c_port);
    end
    io_write(ppi_cmd_port, 8'h82);   // Mode set, port C untouched
    io_read(ppi_c_port);
    io_read(ppi_b_port);
    btn = 6'($random(seed));
    io_write(psg_reg_port, 8'h0e);
    io_read(psg_read_port);
    io_write(psg_reg_port, 8'h07);
    io_read(psg_read_port);

    // Slot decoding
    repeat (24) begin
      io_write(ppi_a_port, 8'($random(seed)));
      rom_32k = 1'($random(seed));
      mem_access(16'($random(seed)), 8'h00, 1'b0);
      mem_access(16'($random(seed)), 8'($random(seed)), 1'b1);
    end

    pass_edge();
    if (u_dut.u_sva.fail_count != 0) begin
      $display("Test failed");
      $fatal(1, "Bound assertions reported %0d failures", u_dut.u_sva.fail_count);
    end else begin
      $display("Test passed");
      $finish;
    end
  end

endmodule

//--- sources.f
source/msx_bus_pkg.sv
source/msx_vdp_pkg.sv
source/cpu_clock_enable.sv
source/io_port_decode.sv
source/vdp_cpu_port.sv
source/ppi_psg_regs.sv
source/slot_decoder.sv
source/msx_io_top.sv
tb/msx_io_sva.sv
tb/msx_io_tb.sv
